//--- files.f
+incdir+src
src/coupler_pkg.sv
src/fifo_if.sv
src/word_fifo.sv
src/word_pairer.sv
src/coupler_top.sv
verif/coupler_tb.sv

//--- run.sh
#!/bin/sh
# Compile the coupler and its testbench with Verilator, then run the simulation.
# The exit status is nonzero when the build or the testbench fails.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f files.f \
  --top-module coupler_tb \
  -o coupler_sim &&
./obj_dir/coupler_sim ||
{ echo "coupler simulation failed"; exit 1; }

//--- src/coupler_consts.svh
`ifndef COUPLER_CONSTS_SVH
`define COUPLER_CONSTS_SVH

// Shared sizing for the width coupler

// =====================================================================
// Word geometry
// =====================================================================
`define COUPLER_WORD_W 16

// =====================================================================
// Buffering
// =====================================================================
// Entries in each of the input and output FIFOs
`define COUPLER_FIFO_DEPTH 8

`endif

//--- src/coupler_pkg.sv
package coupler_pkg;

  `include "coupler_consts.svh"

  // One narrow word as it enters the coupler
  typedef logic [`COUPLER_WORD_W-1:0] word_t;

  // Double-width word leaving the coupler
  // The first word of a pair lands in the low half
  typedef struct packed {
    word_t hi;
    word_t lo;
  } pair_t;

  // Pairing engine states
  // PAIR_LOW waits for the first word, PAIR_HIGH holds it
  typedef enum logic {
    PAIR_LOW,
    PAIR_HIGH
  } pair_state_e;

endpackage

//--- src/coupler_top.sv
`timescale 1ns/1ps

`include "coupler_consts.svh"

module coupler_top (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  coupler_pkg::word_t i_data,
  input  logic               i_enq,
  output logic               o_full,
  output coupler_pkg::pair_t o_data,
  input  logic               i_deq,
  output logic               o_empty
);

  import coupler_pkg::*;

  localparam int WORD_W = $bits(word_t);
  localparam int PAIR_W = $bits(pair_t);

  fifo_if #(.WIDTH(WORD_W)) in_if ();
  fifo_if #(.WIDTH(PAIR_W)) out_if ();

  // =====================================================================
  // Boundary wiring
  // =====================================================================
  // Narrow words go straight into the input FIFO
  assign in_if.wr_data = i_data;
  assign in_if.enq     = i_enq;
  assign o_full        = in_if.full;

  // Pairs are read straight from the output FIFO
  assign o_data        = out_if.rd_data;
  assign out_if.deq    = i_deq;
  assign o_empty       = out_if.empty;

  // =====================================================================
  // Datapath
  // =====================================================================
  word_fifo #(
    .WIDTH (WORD_W),
    .DEPTH (`COUPLER_FIFO_DEPTH)
  ) i_in_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .f       (in_if.store)
  );

  word_pairer i_pairer (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .src     (in_if.drain),
    .dst     (out_if.fill)
  );

  word_fifo #(
    .WIDTH (PAIR_W),
    .DEPTH (`COUPLER_FIFO_DEPTH)
  ) i_out_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .f       (out_if.store)
  );

endmodule

//--- src/fifo_if.sv
`timescale 1ns/1ps

`include "coupler_consts.svh"

interface fifo_if #(
  parameter int WIDTH = `COUPLER_WORD_W
);

  logic [WIDTH-1:0] wr_data;
  logic             enq;
  logic             full;
  logic [WIDTH-1:0] rd_data;
  logic             deq;
  logic             empty;

  // The FIFO itself
  modport store (input wr_data, input enq, input deq,
                 output full, output empty, output rd_data);

  // Producer side
  modport fill (output wr_data, output enq, input full);

  // Consumer side
  modport drain (output deq, input rd_data, input empty);

endinterface

//--- src/word_fifo.sv
`timescale 1ns/1ps

`include "coupler_consts.svh"

module word_fifo #(
  parameter int WIDTH = `COUPLER_WORD_W,
  parameter int DEPTH = `COUPLER_FIFO_DEPTH
) (
  input logic   i_clk,
  input logic   i_rst_n,
  fifo_if.store f
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // =====================================================================
  // Storage and bookkeeping
  // =====================================================================
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Pointers wrap at DEPTH so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Flags come straight from the count, so they move on the edge of the access
  assign f.full    = (count == CNT_W'(DEPTH));
  assign f.empty   = (count == '0);
  assign f.rd_data = mem[rd_ptr];

  // Requests against a full or empty FIFO are dropped here
  assign do_wr = f.enq && !f.full;
  assign do_rd = f.deq && !f.empty;

  // =====================================================================
  // Write and read
  // =====================================================================
  always_ff @(posedge i_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= f.wr_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // A read and a write together leave the occupancy alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/word_pairer.sv
`timescale 1ns/1ps

module word_pairer (
  input logic   i_clk,
  input logic   i_rst_n,
  fifo_if.drain src,
  fifo_if.fill  dst
);

  import coupler_pkg::*;

  // =====================================================================
  // State and datapath
  // =====================================================================
  pair_state_e state;
  pair_state_e state_nxt;
  word_t       low_word;
  word_t       head;
  pair_t       pair;
  logic        head_zero;
  logic        step;
  logic        emit;
  logic        load_low;

  assign head      = src.rd_data;
  assign head_zero = (head == '0);

  // Nothing moves unless there is a word to take and room for a pair
  assign step = !src.empty && !dst.full;

  // =====================================================================
  // Pairing rule
  // =====================================================================
  always_comb begin
    state_nxt = state;
    emit      = 1'b0;
    load_low  = 1'b0;
    pair      = '0;
    case (state)
      PAIR_LOW: begin
        if (step) begin
          if (head_zero) begin
            // Terminator at a pair boundary flushes out a zero pair
            emit = 1'b1;
          end else begin
            load_low  = 1'b1;
            state_nxt = PAIR_HIGH;
          end
        end
      end
      PAIR_HIGH: begin
        // Second word goes in as-is, zero or not
        pair.lo = low_word;
        pair.hi = head;
        if (step) begin
          emit      = 1'b1;
          state_nxt = PAIR_LOW;
        end
      end
      default: begin
        state_nxt = PAIR_LOW;
      end
    endcase
  end

  // Every step consumes exactly one input word
  assign src.deq     = step;
  assign dst.enq     = emit;
  assign dst.wr_data = pair;

  // =====================================================================
  // Registers
  // =====================================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= PAIR_LOW;
    end else begin
      state <= state_nxt;
    end
  end

  // Low half of the pair being built
  always_ff @(posedge i_clk) begin
    if (load_low) begin
      low_word <= head;
    end
  end

endmodule

//--- verif/coupler_tb.sv
`timescale 1ns/1ps

`include "coupler_consts.svh"

module coupler_tb;

  import coupler_pkg::*;

  localparam int N_WORDS     = 33;
  localparam int N_PAIRS     = 19;
  localparam int HOLD_CYCLES = 6 * `COUPLER_FIFO_DEPTH;
  localparam int LIMIT       = 8 * N_WORDS + HOLD_CYCLES + 100;

  logic  clk;
  logic  rst_n;
  word_t in_data;
  logic  in_enq;
  logic  in_full;
  pair_t out_data;
  logic  out_deq;
  logic  out_empty;

  // =====================================================================
  // Stimulus and expected pairs
  // =====================================================================
  // Zero words show up both at a pair boundary and as a high half
  word_t stim [N_WORDS] = '{
    16'h1111, 16'h2222, 16'h0000, 16'h3333, 16'h0000, 16'h0000, 16'h0000,
    16'ha5a5, 16'h5a5a, 16'h0001, 16'h8000, 16'h1234, 16'h5678, 16'h9abc,
    16'hdef0, 16'hffff, 16'hfffe, 16'h0f0f, 16'hf0f0, 16'h0000, 16'h7777,
    16'h0000, 16'h0102, 16'h0304, 16'h0506, 16'h0708, 16'h090a, 16'h0b0c,
    16'h0d0e, 16'h0f10, 16'hc0de, 16'hbeef, 16'h0000
  };

  pair_t expected [N_PAIRS] = '{
    32'h2222_1111, 32'h0000_0000, 32'h0000_3333, 32'h0000_0000, 32'h0000_0000,
    32'h5a5a_a5a5, 32'h8000_0001, 32'h5678_1234, 32'hdef0_9abc, 32'hfffe_ffff,
    32'hf0f0_0f0f, 32'h0000_0000, 32'h0000_7777, 32'h0304_0102, 32'h0708_0506,
    32'h0b0c_090a, 32'h0f10_0d0e, 32'hbeef_c0de, 32'h0000_0000
  };

  int          in_idx;
  int          out_idx;
  int          cycles;
  logic        hold;
  logic        take;
  logic [7:0]  lfsr;

  coupler_top i_dut (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_data  (in_data),
    .i_enq   (in_enq),
    .o_full  (in_full),
    .o_data  (out_data),
    .i_deq   (out_deq),
    .o_empty (out_empty)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    logic fb;
    fb = s[7] ^ s[5] ^ s[4] ^ s[3];
    return {s[6:0], fb};
  endfunction

  // Walks the stimulus through the pairing rule and holds it against the table
  task automatic check_expected_table();
    pair_state_e st;
    word_t       low;
    pair_t       p;
    logic        emitted;
    int          n;
    st  = PAIR_LOW;
    low = '0;
    n   = 0;
    for (int i = 0; i < N_WORDS; i++) begin
      p       = '0;
      emitted = 1'b1;
      if (st == PAIR_LOW && stim[i] == '0) begin
        p = '0;
      end else if (st == PAIR_LOW) begin
        low     = stim[i];
        st      = PAIR_HIGH;
        emitted = 1'b0;
      end else begin
        p.lo = low;
        p.hi = stim[i];
        st   = PAIR_LOW;
      end
      if (emitted) begin
        assert (n < N_PAIRS) else stop_on_error(
          "expected table has fewer pairs than the stimulus makes");
        assert (p == expected[n]) else stop_on_error($sformatf(
          "error at %0t: model pair %0d is %h, table holds %h", $time, n, p, expected[n]));
        n++;
      end
    end
    assert (n == N_PAIRS && st == PAIR_LOW) else stop_on_error(
      "expected table length does not match the stimulus");
  endtask

  // =====================================================================
  // Watchdog
  // =====================================================================
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      stop_on_error($sformatf("timeout: the run did not finish within %0d cycles", LIMIT));
    end
  end

  // =====================================================================
  // Main sequence
  // =====================================================================
  initial begin
    rst_n       = 1'b0;
    in_data     = '0;
    in_enq      = 1'b0;
    out_deq     = 1'b0;
    in_idx      = 0;
    out_idx     = 0;
    cycles      = 0;
    hold        = 1'b1;
    lfsr        = 8'd19;
    check_expected_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (out_empty && !in_full) else stop_on_error(
      "after reset o_empty must be high and o_full low");

    while (!(out_idx == N_PAIRS && in_idx == N_WORDS && out_empty)) begin
      if (in_idx < N_WORDS && !in_full) begin
        in_data = stim[in_idx];
        in_enq  = 1'b1;
        in_idx++;
      end else begin
        in_enq = 1'b0;
      end

      // Reads stay off until back-pressure reaches the input side
      if (hold) begin
        if (in_full) begin
          hold = 1'b0;
        end else begin
          assert (in_idx < N_WORDS) else stop_on_error(
            "o_full never rose while reads were held off");
        end
      end

      if (hold) begin
        out_deq = 1'b0;
      end else begin
        lfsr    = lfsr_step(lfsr);
        take    = lfsr[0];
        out_deq = take;
        if (take && !out_empty) begin
          assert (out_idx < N_PAIRS) else stop_on_error($sformatf(
            "error at %0t: extra pair %h after the last expected one", $time, out_data));
          assert (out_data == expected[out_idx]) else stop_on_error($sformatf(
            "error at %0t: pair %0d is %h, expected %h", $time, out_idx, out_data,
            expected[out_idx]));
          out_idx++;
        end
      end
      @(negedge clk);
    end

    // Nothing may follow the last expected pair
    in_enq  = 1'b0;
    out_deq = 1'b1;
    repeat (4) begin
      @(negedge clk);
      assert (out_empty) else stop_on_error($sformatf(
        "error at %0t: unexpected pair %h after the end of the stream", $time, out_data));
    end
    $display(">>> PASS");
    $finish;
  end

endmodule
